// File: cy_bridge_top.f
src/cy_bridge_pkg.sv
src/cy_link_rx.sv
src/cmd_fifo.sv
src/cmd_executor.sv
src/cy_link_tx.sv
src/cy_bridge_top.sv
dv/cy_bridge_props.sv
dv/cy_bridge_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cy_bridge_tb
FILELIST = cy_bridge_top.f
OBJDIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf $(OBJDIR)

// File: dv/cy_bridge_tb.sv
`timescale 1ns/1ps

module cy_bridge_tb
  import cy_bridge_pkg::*;
;

  localparam int HALF        = 4;                     // strobe half period in clocks
  localparam int FRAME_CLKS  = (FRAME_BITS + 1) * 2 * HALF;
  localparam int TEST_FRAMES = 2 + 10 + 42 + 11 + 9 + 190;  // per-test budgets summed
  localparam int LIMIT       = 2 * TEST_FRAMES * FRAME_CLKS;
  localparam int OVF_MAX     = 160;                   // read frames tried in test 6

  logic  sys_clk;
  logic  sys_rst_n;
  logic  link_strobe;
  logic  link_rx_bit;
  logic  link_tx_bit;
  logic  busy;
  logic  overflow;
  word_t ref_mem [256];
  word_t reply_q [$];
  word_t dec_word;
  word_t got;
  logic  dec_active;
  int    dec_idx;
  int    err_cnt;
  int    test_cnt;
  int    test_fail;
  int    cycle_cnt = 0;
  int    err_mark;
  byte_t addrs [6];
  logic  used [256];
  byte_t a;
  byte_t tmp;
  int    j;
  int    n;

  cy_bridge_top cy_bridge_top_i (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .link_strobe (link_strobe),
    .link_rx_bit (link_rx_bit),
    .link_tx_bit (link_tx_bit),
    .busy        (busy),
    .overflow    (overflow)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("run stopped after %0d cycles without finishing the tests", LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic compare_value(input string sig, input word_t exp, input word_t act);
    assert (exp === act)
    else begin
      $display("[FAIL] %s expected 0x%h got 0x%h", sig, exp, act);
      err_cnt++;
    end
  endtask

  // decodes the reply line from one sample per strobe period
  task automatic decode_tx(input logic v);
    if (!dec_active) begin
      dec_active = v;  // start bit
      dec_idx    = 0;
    end else if (dec_idx < REPLY_BITS) begin
      dec_word[dec_idx] = v;
      dec_idx++;
    end else begin
      assert (v == 1'b0)
      else begin
        $display("reply stop bit did not return the line low");
        err_cnt++;
      end
      reply_q.push_back(dec_word);
      dec_active = 1'b0;
    end
  endtask

  task automatic strobe_bit(input logic b);
    link_rx_bit = b;
    repeat (HALF) @(posedge sys_clk);
    #1 link_strobe = 1'b1;
    repeat (HALF) @(posedge sys_clk);
    #1 decode_tx(link_tx_bit);  // tx bit settled after the rise
    link_strobe = 1'b0;
  endtask

  task automatic send_frame(input byte_t cmd, input byte_t operand);
    strobe_bit(1'b1);
    for (int i = 0; i < 8; i++) strobe_bit(cmd[i]);
    for (int i = 0; i < 8; i++) strobe_bit(operand[i]);
  endtask

  task automatic wait_replies(input int count);
    int k;
    k = 0;
    while (reply_q.size() < count && k < 60 * count) begin
      strobe_bit(1'b0);
      k++;
    end
    assert (reply_q.size() >= count)
    else begin
      $display("expected reply frame never arrived");
      err_cnt++;
    end
  endtask

  task automatic write_word(input byte_t addr, input word_t data);
    send_frame(OP_SET_DATA0, data[7:0]);
    send_frame(OP_SET_DATA1, data[15:8]);
    send_frame(OP_SET_ADDR0, addr);
    send_frame(OP_MEM_WRITE, 8'h00);
    ref_mem[addr] = data;
  endtask

  task automatic read_check(input byte_t addr);
    send_frame(OP_SET_ADDR0, addr);
    send_frame(OP_MEM_READ, 8'h00);
    wait_replies(1);
    if (reply_q.size() > 0) begin
      compare_value("reply_word", ref_mem[addr], reply_q.pop_front());
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == err_mark) begin
      $display("test %0d %s ok", test_cnt, name);
    end else begin
      test_fail++;
      $display("test %0d %s FAILED", test_cnt, name);
    end
    err_mark = err_cnt;
  endtask

  initial begin
    void'($urandom(78451));
    err_cnt     = 0;
    test_cnt    = 0;
    test_fail   = 0;
    err_mark    = 0;
    dec_idx     = 0;
    dec_active  = 1'b0;
    dec_word    = '0;
    sys_rst_n   = 1'b0;
    link_strobe = 1'b0;
    link_rx_bit = 1'b0;
    for (int i = 0; i < 256; i++) used[i] = 1'b0;
    repeat (10) @(posedge sys_clk);
    #1 sys_rst_n = 1'b1;

    compare_value("busy", 16'h0, {15'h0, busy});  // idle right after reset
    compare_value("overflow", 16'h0, {15'h0, overflow});
    compare_value("link_tx_bit", 16'h0, {15'h0, link_tx_bit});
    repeat (20) strobe_bit(1'b0);
    compare_value("reply_count", 16'h0, 16'(reply_q.size()));
    end_test("reset and idle strobes");

    send_frame(OP_SET_ADDR1, 8'($urandom));  // high address bytes leave the memory index alone
    send_frame(OP_SET_ADDR2, 8'($urandom));
    a = 8'($urandom);
    used[a] = 1'b1;
    write_word(a, 16'($urandom));
    read_check(a);
    end_test("single write and read");

    for (int i = 0; i < 6; i++) begin
      do a = 8'($urandom); while (used[a]);
      used[a]  = 1'b1;
      addrs[i] = a;
      write_word(a, 16'($urandom));
    end
    for (int i = 5; i > 0; i--) begin  // shuffle read order
      j = $urandom % (i + 1);
      tmp      = addrs[i];
      addrs[i] = addrs[j];
      addrs[j] = tmp;
    end
    for (int i = 0; i < 6; i++) read_check(addrs[i]);
    end_test("random writes, shuffled reads");

    // a stray write would put the inverted word here
    send_frame(OP_SET_DATA0, ~ref_mem[addrs[0]][7:0]);
    send_frame(OP_SET_DATA1, ~ref_mem[addrs[0]][15:8]);
    send_frame(OP_SET_ADDR0, addrs[0]);
    send_frame(8'h5A, 8'h3C);
    repeat (30) strobe_bit(1'b0);
    compare_value("reply_count", 16'h0, 16'(reply_q.size()));
    read_check(addrs[0]);
    end_test("unknown opcode ignored");

    send_frame(OP_SET_ADDR0, addrs[1]);
    for (int i = 0; i < 3; i++) begin
      send_frame(OP_MEM_READ, 8'h00);  // later replies wait behind the one on the line
    end
    wait_replies(3);
    for (int i = 0; i < 3; i++) begin
      if (reply_q.size() > 0) begin
        compare_value("reply_word", ref_mem[addrs[1]], reply_q.pop_front());
      end
    end
    compare_value("busy", 16'h0, {15'h0, busy});
    end_test("queued reads under back-pressure");

    send_frame(OP_SET_ADDR0, addrs[2]);
    n = 0;
    while (!overflow && n < OVF_MAX) begin
      send_frame(OP_MEM_READ, 8'h00);
      n++;
    end
    compare_value("overflow", 16'h1, {15'h0, overflow});
    assert (n > 4 + 1)
    else begin
      $display("overflow rose before the queue could fill");
      err_cnt++;
    end
    j = 0;
    while (busy && j < 4000) begin  // drain what was queued
      strobe_bit(1'b0);
      j++;
    end
    compare_value("busy", 16'h0, {15'h0, busy});
    while (reply_q.size() > 0) begin
      got = reply_q.pop_front();
      compare_value("reply_word", ref_mem[addrs[2]], got);
    end
    compare_value("overflow", 16'h1, {15'h0, overflow});
    end_test("overflow on full queue");

    $display("%0d tests run, %0d failed, %0d checks failed", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: dv/cy_bridge_props.sv
`timescale 1ns/1ps

module cy_bridge_props (
  input logic sys_clk,
  input logic sys_rst_n,
  input logic link_tx_bit,
  input logic tx_busy,
  input logic overflow,
  input logic rx_valid
);

  // reply line idles low
  tx_idle_low: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !tx_busy |-> !link_tx_bit)
    else $error("link_tx_bit high while the transmitter is idle");

  // sticky flag
  overflow_sticky: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !$fell(overflow))
    else $error("overflow fell without reset");

  rx_valid_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    rx_valid |=> !rx_valid)
    else $error("rx_valid held longer than one cycle");

endmodule

bind cy_bridge_top cy_bridge_props cy_bridge_props_i (
  .sys_clk     (sys_clk),
  .sys_rst_n   (sys_rst_n),
  .link_tx_bit (link_tx_bit),
  .tx_busy     (tx_busy),
  .overflow    (overflow),
  .rx_valid    (rx_valid)
);

// File: src/cy_bridge_top.sv
`timescale 1ns/1ps

module cy_bridge_top
  import cy_bridge_pkg::*;
#(
  parameter int FIFO_DEPTH = 4,
  parameter int MEM_ADDR_W = 8
) (
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic link_strobe,
  input  logic link_rx_bit,
  output logic link_tx_bit,
  output logic busy,
  output logic overflow
);

  logic         strobe_rise;
  cmd_frame_t   rx_frame;
  logic         rx_valid;
  cmd_frame_t   head_frame;
  logic         cmd_valid;
  logic         cmd_ready;
  logic         pending;
  reply_frame_t reply_frame;
  logic         reply_valid;
  logic         reply_ready;
  logic         exec_busy;
  logic         tx_busy;

  cy_link_rx u_link_rx (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .link_strobe (link_strobe),
    .link_rx_bit (link_rx_bit),
    .strobe_rise (strobe_rise),
    .rx_frame    (rx_frame),
    .rx_valid    (rx_valid)
  );

  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_cmd_fifo (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .push_frame (rx_frame),
    .push_valid (rx_valid),
    .head_frame (head_frame),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .overflow   (overflow),
    .pending    (pending)
  );

  cmd_executor #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_cmd_executor (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .cmd_frame   (head_frame),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .reply_frame (reply_frame),
    .reply_valid (reply_valid),
    .reply_ready (reply_ready),
    .exec_busy   (exec_busy)
  );

  cy_link_tx u_link_tx (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .strobe_rise (strobe_rise),  // same edges as the receiver
    .reply_frame (reply_frame),
    .reply_valid (reply_valid),
    .reply_ready (reply_ready),
    .link_tx_bit (link_tx_bit),
    .tx_busy     (tx_busy)
  );

  assign busy = pending | exec_busy | tx_busy;

endmodule

// File: src/cy_link_tx.sv
`timescale 1ns/1ps

module cy_link_tx
  import cy_bridge_pkg::*;
(
  input  logic         sys_clk,
  input  logic         sys_rst_n,
  input  logic         strobe_rise,
  input  reply_frame_t reply_frame,
  input  logic         reply_valid,
  output logic         reply_ready,
  output logic         link_tx_bit,
  output logic         tx_busy
);

  localparam int CNT_W = $clog2(REPLY_BITS);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_PAYLOAD,
    TX_STOP
  } tx_state_e;

  tx_state_e             state_q;
  logic [CNT_W-1:0]      bit_cnt;
  logic [REPLY_BITS-1:0] shift_q;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state_q     <= TX_IDLE;
      bit_cnt     <= '0;
      shift_q     <= '0;
      link_tx_bit <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (reply_valid) begin
            shift_q <= reply_frame;  // low byte sits in the low bits
            bit_cnt <= '0;
            state_q <= TX_START;
          end
        end
        TX_START: begin
          if (strobe_rise) begin
            link_tx_bit <= 1'b1;  // start bit
            state_q     <= TX_PAYLOAD;
          end
        end
        TX_PAYLOAD: begin
          if (strobe_rise) begin
            link_tx_bit <= shift_q[0];
            shift_q     <= shift_q >> 1;
            bit_cnt     <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_W'(REPLY_BITS - 1)) begin
              state_q <= TX_STOP;
            end
          end
        end
        TX_STOP: begin
          if (strobe_rise) begin
            link_tx_bit <= 1'b0;  // line back low marks the end
            state_q     <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  assign reply_ready = (state_q == TX_IDLE);
  assign tx_busy     = (state_q != TX_IDLE);

endmodule

// File: src/cmd_executor.sv
`timescale 1ns/1ps

module cmd_executor
  import cy_bridge_pkg::*;
#(
  parameter int MEM_ADDR_W = 8
) (
  input  logic         sys_clk,
  input  logic         sys_rst_n,
  input  cmd_frame_t   cmd_frame,
  input  logic         cmd_valid,
  output logic         cmd_ready,
  output reply_frame_t reply_frame,
  output logic         reply_valid,
  input  logic         reply_ready,
  output logic         exec_busy
);

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_READ,
    EXEC_REPLY
  } exec_state_e;

  exec_state_e           state_q;
  opcode_e               opcode;
  byte_t                 data0;
  byte_t                 data1;
  byte_t                 addr0;
  byte_t                 addr1;
  byte_t                 addr2;
  logic [23:0]           full_addr;
  logic [MEM_ADDR_W-1:0] mem_addr;
  word_t                 mem [2**MEM_ADDR_W];
  word_t                 rd_data;
  logic                  pop;
  logic                  mem_we;

  assign opcode    = opcode_e'(cmd_frame.cmd);
  assign cmd_ready = (state_q == EXEC_IDLE) && cmd_valid;  // no pop while a reply waits
  assign pop       = cmd_valid && cmd_ready;
  assign mem_we    = pop && (opcode == OP_MEM_WRITE);

  assign full_addr = {addr2, addr1, addr0};
  assign mem_addr  = full_addr[MEM_ADDR_W-1:0];  // low bits pick the word

  // word memory, stands in for the external sdram word port
  always_ff @(posedge sys_clk) begin
    if (mem_we) begin
      mem[mem_addr] <= {data1, data0};
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rd_data <= '0;
    end else if (state_q == EXEC_READ) begin
      rd_data <= mem[mem_addr];  // registered read
    end
  end

  // sequencer and byte registers
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state_q <= EXEC_IDLE;
      data0   <= '0;
      data1   <= '0;
      addr0   <= '0;
      addr1   <= '0;
      addr2   <= '0;
    end else begin
      case (state_q)
        EXEC_IDLE: begin
          if (pop) begin
            case (opcode)
              OP_SET_DATA0: data0 <= cmd_frame.operand;
              OP_SET_DATA1: data1 <= cmd_frame.operand;
              OP_SET_ADDR0: addr0 <= cmd_frame.operand;
              OP_SET_ADDR1: addr1 <= cmd_frame.operand;
              OP_SET_ADDR2: addr2 <= cmd_frame.operand;
              OP_MEM_READ:  state_q <= EXEC_READ;
              default:      state_q <= EXEC_IDLE;  // write done by mem port, rest dropped
            endcase
          end
        end
        EXEC_READ: begin
          state_q <= EXEC_REPLY;
        end
        EXEC_REPLY: begin
          if (reply_ready) begin
            state_q <= EXEC_IDLE;  // transmitter took the word
          end
        end
        default: state_q <= EXEC_IDLE;
      endcase
    end
  end

  assign reply_frame.hi = rd_data[15:8];
  assign reply_frame.lo = rd_data[7:0];
  assign reply_valid    = (state_q == EXEC_REPLY);
  assign exec_busy      = (state_q != EXEC_IDLE);

endmodule

// File: src/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo
  import cy_bridge_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       sys_clk,
  input  logic       sys_rst_n,
  input  cmd_frame_t push_frame,
  input  logic       push_valid,
  output cmd_frame_t head_frame,
  output logic       cmd_valid,
  input  logic       cmd_ready,
  output logic       overflow,
  output logic       pending
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  cmd_frame_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign push = push_valid && !full;  // host cannot be stalled
  assign pop  = cmd_valid && cmd_ready;

  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_frame;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (push_valid && full) begin
        overflow <= 1'b1;  // sticky until reset
      end
    end
  end

  assign head_frame = mem[rd_ptr];
  assign cmd_valid  = (count != '0);
  assign pending    = cmd_valid;

endmodule

// File: src/cy_link_rx.sv
`timescale 1ns/1ps

module cy_link_rx
  import cy_bridge_pkg::*;
(
  input  logic       sys_clk,
  input  logic       sys_rst_n,
  input  logic       link_strobe,
  input  logic       link_rx_bit,
  output logic       strobe_rise,
  output cmd_frame_t rx_frame,
  output logic       rx_valid
);

  localparam int CNT_W = $clog2(FRAME_BITS);

  typedef enum logic {
    RX_IDLE,
    RX_PAYLOAD
  } rx_state_e;

  rx_state_e             state_q;
  logic [2:0]            strobe_sync;  // two sync stages plus edge history
  logic [1:0]            data_sync;    // same depth as the strobe stages
  logic [CNT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-1:0] shift_q;
  logic                  rx_bit;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      strobe_sync <= '0;
      data_sync   <= '0;
    end else begin
      strobe_sync <= {strobe_sync[1:0], link_strobe};
      data_sync   <= {data_sync[0], link_rx_bit};
    end
  end

  assign strobe_rise = strobe_sync[1] & ~strobe_sync[2];
  assign rx_bit      = data_sync[1];  // aligned with strobe_sync[1]

  // frame receiver, one step per strobe rise
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state_q  <= RX_IDLE;
      bit_cnt  <= '0;
      shift_q  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (strobe_rise) begin
        case (state_q)
          RX_IDLE: begin
            if (rx_bit) begin  // start bit
              state_q <= RX_PAYLOAD;
              bit_cnt <= '0;
            end
          end
          RX_PAYLOAD: begin
            shift_q <= {rx_bit, shift_q[FRAME_BITS-1:1]};  // lsb first
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
              state_q  <= RX_IDLE;
              rx_valid <= 1'b1;
            end
          end
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  // command bits arrive first, so they end up in the low half
  assign rx_frame.cmd     = shift_q[7:0];
  assign rx_frame.operand = shift_q[FRAME_BITS-1:8];

endmodule

// File: src/cy_bridge_pkg.sv
package cy_bridge_pkg;

  typedef logic [7:0]  byte_t;  // one byte on the link
  typedef logic [15:0] word_t;  // memory and reply word

  // host command set
  typedef enum byte_t {
    OP_SET_DATA0 = 8'h10,  // data byte 0, low half of the write word
    OP_SET_DATA1 = 8'h11,  // data byte 1, high half
    OP_SET_ADDR0 = 8'h12,
    OP_SET_ADDR1 = 8'h13,
    OP_SET_ADDR2 = 8'h14,
    OP_MEM_WRITE = 8'hA0,  // write {data1, data0} at the address
    OP_MEM_READ  = 8'hA1   // read the word at the address and reply
  } opcode_e;

  typedef struct packed {
    byte_t cmd;      // first byte on the wire
    byte_t operand;  // second byte on the wire
  } cmd_frame_t;

  typedef struct packed {
    byte_t hi;  // sent second
    byte_t lo;  // sent first
  } reply_frame_t;

  localparam int FRAME_BITS = 16;  // payload bits after the start bit
  localparam int REPLY_BITS = 16;

endpackage
